// ==== include/mcpu_cfg.svh ====
`ifndef MCPU_CFG_SVH
`define MCPU_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core configuration
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// First fetch address out of reset
`define MCPU_RESET_PC   32'h1c00_0000

`define MCPU_XLEN       32  // Data and address width
`define MCPU_NREGS      32  // Architectural registers

// Trace write enable, one strobe replicated
`define MCPU_TRACE_WE_W 4

`endif

// ==== design/mcpu_pkg.sv ====
package mcpu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Multi-cycle FSM states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        S_IF  = 3'd0,
        S_ID  = 3'd1,
        S_EXE = 3'd2,
        S_MEM = 3'd3,
        S_WB  = 3'd4
    } state_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU operations
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,   // Also address and link arithmetic
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11   // Source 2 straight through
    } alu_op_e;

    // Immediate formats
    typedef enum logic [2:0] {
        IMM_UI5  = 3'd0,
        IMM_SI12 = 3'd1,
        IMM_SI16 = 3'd2,
        IMM_SI20 = 3'd3,
        IMM_SI26 = 3'd4,
        IMM_FOUR = 3'd5    // Link value offset
    } imm_fmt_e;

endpackage

// ==== design/mcpu_decode.sv ====
`timescale 1ns/1ps
`include "mcpu_cfg.svh"

module mcpu_decode #(
    parameter int RAW = $clog2(`MCPU_NREGS)
) (
    input  logic [`MCPU_XLEN-1:0] instr,
    output mcpu_pkg::alu_op_e     alu_op,
    output logic                  src1_is_pc,
    output logic                  src2_is_imm,
    output logic [`MCPU_XLEN-1:0] imm,
    output logic [`MCPU_XLEN-1:0] br_offs,
    output logic                  is_load,
    output logic                  is_store,
    output logic                  is_branch_cond,
    output logic                  is_beq,
    output logic                  is_jump_reg,
    output logic                  is_jump_rel,
    output logic                  gr_we,
    output logic [RAW-1:0]        dest,
    output logic [RAW-1:0]        rf_raddr1,
    output logic [RAW-1:0]        rf_raddr2
);

    logic [5:0] op_31_26;
    logic [3:0] op_25_22;
    logic [1:0] op_21_20;
    logic [4:0] op_19_15;
    logic       grp_3r;   // Three-register ALU group
    logic       grp_sh;   // Shift-immediate group
    logic       inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic       inst_nor, inst_and, inst_or, inst_xor;
    logic       inst_slli_w, inst_srli_w, inst_srai_w, inst_addi_w;
    logic       inst_lu12i_w, inst_ld_w, inst_st_w, inst_jirl;
    logic       inst_b, inst_bl, inst_beq, inst_bne;
    logic [`MCPU_XLEN-1:0] off16;
    logic [`MCPU_XLEN-1:0] off26;
    mcpu_pkg::imm_fmt_e    imm_fmt;

    assign op_31_26 = instr[31:26];
    assign op_25_22 = instr[25:22];
    assign op_21_20 = instr[21:20];
    assign op_19_15 = instr[19:15];

    assign grp_3r = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    assign grp_sh = (op_31_26 == 6'h00) && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);

    assign inst_add_w   = grp_3r && (op_19_15 == 5'h00);
    assign inst_sub_w   = grp_3r && (op_19_15 == 5'h02);
    assign inst_slt     = grp_3r && (op_19_15 == 5'h04);
    assign inst_sltu    = grp_3r && (op_19_15 == 5'h05);
    assign inst_nor     = grp_3r && (op_19_15 == 5'h08);
    assign inst_and     = grp_3r && (op_19_15 == 5'h09);
    assign inst_or      = grp_3r && (op_19_15 == 5'h0a);
    assign inst_xor     = grp_3r && (op_19_15 == 5'h0b);
    assign inst_slli_w  = grp_sh && (op_19_15 == 5'h01);
    assign inst_srli_w  = grp_sh && (op_19_15 == 5'h09);
    assign inst_srai_w  = grp_sh && (op_19_15 == 5'h11);
    assign inst_addi_w  = (op_31_26 == 6'h00) && (op_25_22 == 4'ha);
    assign inst_lu12i_w = (op_31_26 == 6'h05) && !instr[25];
    assign inst_ld_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h2);
    assign inst_st_w    = (op_31_26 == 6'h0a) && (op_25_22 == 4'h6);
    assign inst_jirl    = (op_31_26 == 6'h13);
    assign inst_b       = (op_31_26 == 6'h14);
    assign inst_bl      = (op_31_26 == 6'h15);
    assign inst_beq     = (op_31_26 == 6'h16);
    assign inst_bne     = (op_31_26 == 6'h17);

    always_comb begin
        alu_op = mcpu_pkg::ALU_ADD;  // Loads, stores, links, addi
        if (inst_sub_w)       alu_op = mcpu_pkg::ALU_SUB;
        else if (inst_slt)    alu_op = mcpu_pkg::ALU_SLT;
        else if (inst_sltu)   alu_op = mcpu_pkg::ALU_SLTU;
        else if (inst_and)    alu_op = mcpu_pkg::ALU_AND;
        else if (inst_nor)    alu_op = mcpu_pkg::ALU_NOR;
        else if (inst_or)     alu_op = mcpu_pkg::ALU_OR;
        else if (inst_xor)    alu_op = mcpu_pkg::ALU_XOR;
        else if (inst_slli_w) alu_op = mcpu_pkg::ALU_SLL;
        else if (inst_srli_w) alu_op = mcpu_pkg::ALU_SRL;
        else if (inst_srai_w) alu_op = mcpu_pkg::ALU_SRA;
        else if (inst_lu12i_w) alu_op = mcpu_pkg::ALU_LUI;
    end

    always_comb begin
        imm_fmt = mcpu_pkg::IMM_SI12;
        if (inst_slli_w || inst_srli_w || inst_srai_w) imm_fmt = mcpu_pkg::IMM_UI5;
        else if (inst_lu12i_w)            imm_fmt = mcpu_pkg::IMM_SI20;
        else if (inst_jirl || inst_bl)    imm_fmt = mcpu_pkg::IMM_FOUR;
        else if (inst_beq || inst_bne)    imm_fmt = mcpu_pkg::IMM_SI16;
        else if (inst_b)                  imm_fmt = mcpu_pkg::IMM_SI26;
    end

    // Word offsets, already shifted by 2
    assign off16 = {{14{instr[25]}}, instr[25:10], 2'b00};
    assign off26 = {{4{instr[9]}}, instr[9:0], instr[25:10], 2'b00};

    always_comb begin
        case (imm_fmt)
            mcpu_pkg::IMM_UI5:  imm = {27'b0, instr[14:10]};
            mcpu_pkg::IMM_SI20: imm = {instr[24:5], 12'b0};
            mcpu_pkg::IMM_SI16: imm = off16;
            mcpu_pkg::IMM_SI26: imm = off26;
            mcpu_pkg::IMM_FOUR: imm = 32'd4;
            default:            imm = {{20{instr[21]}}, instr[21:10]};
        endcase
    end

    assign br_offs = (inst_b || inst_bl) ? off26 : off16;

    assign src1_is_pc  = inst_jirl || inst_bl;
    assign src2_is_imm = inst_slli_w || inst_srli_w || inst_srai_w || inst_addi_w
                      || inst_lu12i_w || inst_ld_w || inst_st_w || inst_jirl || inst_bl;

    assign is_load        = inst_ld_w;
    assign is_store       = inst_st_w;
    assign is_branch_cond = inst_beq || inst_bne;
    assign is_beq         = inst_beq;
    assign is_jump_reg    = inst_jirl;
    assign is_jump_rel    = inst_b || inst_bl;

    // Unknown encodings fall out with no write
    assign gr_we = inst_add_w || inst_sub_w || inst_slt || inst_sltu || inst_nor
                || inst_and || inst_or || inst_xor || inst_slli_w || inst_srli_w
                || inst_srai_w || inst_addi_w || inst_lu12i_w || inst_ld_w
                || inst_jirl || inst_bl;

    assign dest      = inst_bl ? RAW'(1) : instr[4:0];  // bl links to r1
    assign rf_raddr1 = instr[9:5];
    assign rf_raddr2 = (inst_st_w || inst_beq || inst_bne) ? instr[4:0] : instr[14:10];

endmodule

// ==== design/mcpu_alu.sv ====
`timescale 1ns/1ps
`include "mcpu_cfg.svh"

module mcpu_alu (
    input  mcpu_pkg::alu_op_e     alu_op,
    input  logic [`MCPU_XLEN-1:0] alu_src1,
    input  logic [`MCPU_XLEN-1:0] alu_src2,
    output logic [`MCPU_XLEN-1:0] alu_result
);

    logic [4:0]            shamt;
    logic [`MCPU_XLEN-1:0] sum;
    logic [`MCPU_XLEN-1:0] diff;
    logic                  lt_signed;
    logic                  lt_unsigned;

    assign shamt = alu_src2[4:0];  // Low five bits only

    assign sum  = alu_src1 + alu_src2;
    assign diff = alu_src1 - alu_src2;

    assign lt_signed   = $signed(alu_src1) < $signed(alu_src2);
    assign lt_unsigned = alu_src1 < alu_src2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result select
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (alu_op)
            mcpu_pkg::ALU_ADD:  alu_result = sum;
            mcpu_pkg::ALU_SUB:  alu_result = diff;
            mcpu_pkg::ALU_SLT:  alu_result = {31'b0, lt_signed};
            mcpu_pkg::ALU_SLTU: alu_result = {31'b0, lt_unsigned};
            mcpu_pkg::ALU_AND:  alu_result = alu_src1 & alu_src2;
            mcpu_pkg::ALU_NOR:  alu_result = ~(alu_src1 | alu_src2);
            mcpu_pkg::ALU_OR:   alu_result = alu_src1 | alu_src2;
            mcpu_pkg::ALU_XOR:  alu_result = alu_src1 ^ alu_src2;
            mcpu_pkg::ALU_SLL:  alu_result = alu_src1 << shamt;
            mcpu_pkg::ALU_SRL:  alu_result = alu_src1 >> shamt;
            mcpu_pkg::ALU_SRA:  alu_result = $signed(alu_src1) >>> shamt;
            mcpu_pkg::ALU_LUI:  alu_result = alu_src2;  // Immediate is pre-shifted
            default:            alu_result = '0;
        endcase
    end

endmodule

// ==== design/mcpu_regfile.sv ====
`timescale 1ns/1ps
`include "mcpu_cfg.svh"

module mcpu_regfile #(
    parameter int RAW = $clog2(`MCPU_NREGS)
) (
    input  logic                  clk,
    input  logic [RAW-1:0]        raddr1,
    output logic [`MCPU_XLEN-1:0] rdata1,
    input  logic [RAW-1:0]        raddr2,
    output logic [`MCPU_XLEN-1:0] rdata2,
    input  logic                  we,
    input  logic [RAW-1:0]        waddr,
    input  logic [`MCPU_XLEN-1:0] wdata
);

    logic [`MCPU_XLEN-1:0] regs [`MCPU_NREGS];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 always reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== design/mcpu_control.sv ====
`timescale 1ns/1ps
`include "mcpu_cfg.svh"

module mcpu_control #(
    parameter int RAW = $clog2(`MCPU_NREGS)
) (
    input  logic                        clk,
    input  logic                        reset,
    output logic [`MCPU_XLEN-1:0]       inst_sram_addr,
    input  logic [`MCPU_XLEN-1:0]       inst_sram_rdata,
    output logic                        data_sram_we,
    output logic [`MCPU_XLEN-1:0]       data_sram_addr,
    output logic [`MCPU_XLEN-1:0]       data_sram_wdata,
    input  logic [`MCPU_XLEN-1:0]       data_sram_rdata,
    output logic [`MCPU_XLEN-1:0]       instr,
    input  mcpu_pkg::alu_op_e           alu_op,
    input  logic                        src1_is_pc,
    input  logic                        src2_is_imm,
    input  logic [`MCPU_XLEN-1:0]       imm,
    input  logic [`MCPU_XLEN-1:0]       br_offs,
    input  logic                        is_load,
    input  logic                        is_store,
    input  logic                        is_branch_cond,
    input  logic                        is_beq,
    input  logic                        is_jump_reg,
    input  logic                        is_jump_rel,
    input  logic                        gr_we,
    input  logic [RAW-1:0]              dest,
    input  logic [`MCPU_XLEN-1:0]       rs1_data,
    input  logic [`MCPU_XLEN-1:0]       rs2_data,
    output logic [`MCPU_XLEN-1:0]       alu_src1,
    output logic [`MCPU_XLEN-1:0]       alu_src2,
    output mcpu_pkg::alu_op_e           alu_op_q,
    input  logic [`MCPU_XLEN-1:0]       alu_result,
    output logic                        rf_we,
    output logic [RAW-1:0]              rf_waddr,
    output logic [`MCPU_XLEN-1:0]       rf_wdata,
    output logic [`MCPU_XLEN-1:0]       debug_wb_pc,
    output logic [`MCPU_TRACE_WE_W-1:0] debug_wb_rf_we,
    output logic [RAW-1:0]              debug_wb_rf_wnum,
    output logic [`MCPU_XLEN-1:0]       debug_wb_rf_wdata
);

    mcpu_pkg::state_e      state;
    mcpu_pkg::state_e      state_nxt;
    logic [`MCPU_XLEN-1:0] pc;
    logic [`MCPU_XLEN-1:0] npc_q;     // Resolved next PC, held past ID
    logic [`MCPU_XLEN-1:0] rkd_q;     // Store data
    logic [`MCPU_XLEN-1:0] result_q;
    logic [`MCPU_XLEN-1:0] mem_q;
    logic                  br_taken;
    logic [`MCPU_XLEN-1:0] br_target;
    logic [`MCPU_XLEN-1:0] next_pc;
    logic                  id_done;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Branch resolution in ID
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign br_taken = is_jump_reg || is_jump_rel
                   || (is_branch_cond && (is_beq == (rs1_data == rs2_data)));
    assign br_target = is_jump_reg ? (rs1_data + br_offs) : (pc + br_offs);
    assign next_pc   = br_taken ? br_target : (pc + 32'd4);

    // b, beq and bne finish in ID
    assign id_done = is_branch_cond || (is_jump_rel && !gr_we);

    always_comb begin
        case (state)
            mcpu_pkg::S_IF:  state_nxt = mcpu_pkg::S_ID;
            mcpu_pkg::S_ID:  state_nxt = id_done ? mcpu_pkg::S_IF : mcpu_pkg::S_EXE;
            mcpu_pkg::S_EXE: state_nxt = (is_load || is_store) ? mcpu_pkg::S_MEM : mcpu_pkg::S_WB;
            mcpu_pkg::S_MEM: state_nxt = is_load ? mcpu_pkg::S_WB : mcpu_pkg::S_IF;
            default:         state_nxt = mcpu_pkg::S_IF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mcpu_pkg::S_IF;
            pc    <= `MCPU_RESET_PC;
        end else begin
            state <= state_nxt;
            if ((state != mcpu_pkg::S_IF) && (state_nxt == mcpu_pkg::S_IF)) begin
                pc <= (state == mcpu_pkg::S_ID) ? next_pc : npc_q;
            end
        end
    end

    // Datapath registers, loaded per state
    always_ff @(posedge clk) begin
        case (state)
            mcpu_pkg::S_IF: instr <= inst_sram_rdata;
            mcpu_pkg::S_ID: begin
                alu_op_q <= alu_op;
                alu_src1 <= src1_is_pc ? pc : rs1_data;
                alu_src2 <= src2_is_imm ? imm : rs2_data;
                rkd_q    <= rs2_data;
                npc_q    <= next_pc;
            end
            mcpu_pkg::S_EXE: begin
                result_q        <= alu_result;
                data_sram_addr  <= alu_result;
                data_sram_wdata <= rkd_q;
            end
            mcpu_pkg::S_MEM: mem_q <= data_sram_rdata;
            default: begin
            end
        endcase
    end

    // Write strobe held high through MEM only
    always_ff @(posedge clk) begin
        if (reset) begin
            data_sram_we <= 1'b0;
        end else begin
            data_sram_we <= (state == mcpu_pkg::S_EXE) && is_store;
        end
    end

    assign inst_sram_addr = pc;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Writeback and trace
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign rf_we    = (state == mcpu_pkg::S_WB) && gr_we && (dest != '0);
    assign rf_waddr = dest;
    assign rf_wdata = is_load ? mem_q : result_q;

    assign debug_wb_pc       = pc;  // PC not yet advanced in WB
    assign debug_wb_rf_we    = {`MCPU_TRACE_WE_W{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

// ==== design/mcpu_top.sv ====
`timescale 1ns/1ps
`include "mcpu_cfg.svh"

module mcpu_top (
    input  logic                        clk,
    input  logic                        reset,
    output logic                        inst_sram_we,
    output logic [`MCPU_XLEN-1:0]       inst_sram_addr,
    output logic [`MCPU_XLEN-1:0]       inst_sram_wdata,
    input  logic [`MCPU_XLEN-1:0]       inst_sram_rdata,
    output logic                        data_sram_we,
    output logic [`MCPU_XLEN-1:0]       data_sram_addr,
    output logic [`MCPU_XLEN-1:0]       data_sram_wdata,
    input  logic [`MCPU_XLEN-1:0]       data_sram_rdata,
    output logic [`MCPU_XLEN-1:0]       debug_wb_pc,
    output logic [`MCPU_TRACE_WE_W-1:0] debug_wb_rf_we,
    output logic [$clog2(`MCPU_NREGS)-1:0] debug_wb_rf_wnum,
    output logic [`MCPU_XLEN-1:0]       debug_wb_rf_wdata
);

    localparam int RAW = $clog2(`MCPU_NREGS);

    logic [`MCPU_XLEN-1:0] instr;
    mcpu_pkg::alu_op_e     alu_op;
    mcpu_pkg::alu_op_e     alu_op_q;
    logic                  src1_is_pc, src2_is_imm;
    logic [`MCPU_XLEN-1:0] imm, br_offs;
    logic                  is_load, is_store, is_branch_cond, is_beq;
    logic                  is_jump_reg, is_jump_rel, gr_we;
    logic [RAW-1:0]        dest, rf_raddr1, rf_raddr2, rf_waddr;
    logic [`MCPU_XLEN-1:0] rs1_data, rs2_data, rf_wdata;
    logic                  rf_we;
    logic [`MCPU_XLEN-1:0] alu_src1, alu_src2, alu_result;

    // Instruction memory is read-only
    assign inst_sram_we    = 1'b0;
    assign inst_sram_wdata = '0;

    mcpu_control #(.RAW(RAW)) u_control (
        .clk, .reset,
        .inst_sram_addr, .inst_sram_rdata,
        .data_sram_we, .data_sram_addr, .data_sram_wdata, .data_sram_rdata,
        .instr, .alu_op, .src1_is_pc, .src2_is_imm, .imm, .br_offs,
        .is_load, .is_store, .is_branch_cond, .is_beq, .is_jump_reg, .is_jump_rel,
        .gr_we, .dest, .rs1_data, .rs2_data,
        .alu_src1, .alu_src2, .alu_op_q, .alu_result,
        .rf_we, .rf_waddr, .rf_wdata,
        .debug_wb_pc, .debug_wb_rf_we, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    mcpu_decode #(.RAW(RAW)) u_decode (
        .instr, .alu_op, .src1_is_pc, .src2_is_imm, .imm, .br_offs,
        .is_load, .is_store, .is_branch_cond, .is_beq, .is_jump_reg, .is_jump_rel,
        .gr_we, .dest, .rf_raddr1, .rf_raddr2
    );

    mcpu_alu u_alu (
        .alu_op     (alu_op_q),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result)
    );

    mcpu_regfile #(.RAW(RAW)) u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .rdata1 (rs1_data),
        .raddr2 (rf_raddr2),
        .rdata2 (rs2_data),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

endmodule

// ==== sim/mcpu_mem_model.sv ====
`timescale 1ns/1ps
`include "mcpu_cfg.svh"

module mcpu_mem_model #(
    parameter int words = 1024
) (
    input  logic                  clk,
    input  logic [`MCPU_XLEN-1:0] inst_addr,
    output logic [`MCPU_XLEN-1:0] inst_rdata,
    input  logic                  data_we,
    input  logic [`MCPU_XLEN-1:0] data_addr,
    input  logic [`MCPU_XLEN-1:0] data_wdata,
    output logic [`MCPU_XLEN-1:0] data_rdata
);

    localparam int iw = $clog2(words);

    logic [`MCPU_XLEN-1:0] imem [words];
    logic [`MCPU_XLEN-1:0] dmem [words];

    // Word index from the low address bits, upper bits alias
    assign inst_rdata = imem[inst_addr[iw+1:2]];
    assign data_rdata = dmem[data_addr[iw+1:2]];

    always @(posedge clk) begin
        if (data_we) begin
            dmem[data_addr[iw+1:2]] <= data_wdata;
        end
    end

    task automatic clear_inst();
        int i;
        for (i = 0; i < words; i++) begin
            imem[i] = '0;  // Unknown encoding, runs as a no-op
        end
    endtask

    task automatic load_inst(input int idx, input logic [`MCPU_XLEN-1:0] word);
        imem[idx] = word;
    endtask

    // Each word holds its own byte address
    task automatic fill_data();
        int i;
        for (i = 0; i < words; i++) begin
            dmem[i] = 32'hd000_0000 | (i << 2);
        end
    endtask

    function automatic logic [`MCPU_XLEN-1:0] peek_data(input logic [`MCPU_XLEN-1:0] addr);
        return dmem[addr[iw+1:2]];
    endfunction

endmodule

// ==== sim/mcpu_tb.sv ====
`timescale 1ns/1ps
`include "mcpu_cfg.svh"

module mcpu_tb;

    localparam int clk_period  = 40;
    localparam int total_words = 80;  // All test programs together
    localparam int n_tests     = 5;
    localparam int watchdog_cycles = total_words * 5 + n_tests * 40;
    localparam logic [31:0] base_pc = `MCPU_RESET_PC;

    logic                        clk;
    logic                        reset;
    logic                        inst_sram_we;
    logic [`MCPU_XLEN-1:0]       inst_sram_addr, inst_sram_wdata, inst_sram_rdata;
    logic                        data_sram_we;
    logic [`MCPU_XLEN-1:0]       data_sram_addr, data_sram_wdata, data_sram_rdata;
    logic [`MCPU_XLEN-1:0]       debug_wb_pc, debug_wb_rf_wdata;
    logic [`MCPU_TRACE_WE_W-1:0] debug_wb_rf_we;
    logic [4:0]                  debug_wb_rf_wnum;

    integer      seed;
    int          cyc = 0;
    int          pending, budget, test_errs, n_pass, n_fail;
    logic [31:0] m_reg [32];  // Architectural register model
    logic [31:0] prog [$];
    logic [31:0] exp_pc [$], exp_data [$], got_pc [$], got_data [$];
    logic [4:0]  exp_num [$], got_num [$];
    int          exp_gap [$], got_cyc [$];

    mcpu_top DUT (
        .clk, .reset,
        .inst_sram_we, .inst_sram_addr, .inst_sram_wdata, .inst_sram_rdata,
        .data_sram_we, .data_sram_addr, .data_sram_wdata, .data_sram_rdata,
        .debug_wb_pc, .debug_wb_rf_we, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    mcpu_mem_model u_mem (
        .clk        (clk),
        .inst_addr  (inst_sram_addr),
        .inst_rdata (inst_sram_rdata),
        .data_we    (data_sram_we),
        .data_addr  (data_sram_addr),
        .data_wdata (data_sram_wdata),
        .data_rdata (data_sram_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // Trace is stable mid-cycle
    always @(negedge clk) begin
        if (!reset && debug_wb_rf_we != '0) begin
            compare_word("debug_wb_rf_we", {`MCPU_TRACE_WE_W{1'b1}}, debug_wb_rf_we);
            got_pc.push_back(debug_wb_pc);
            got_num.push_back(debug_wb_rf_wnum);
            got_data.push_back(debug_wb_rf_wdata);
            got_cyc.push_back(cyc);
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired at %0t, a test never completed", $time);
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic compare_word(input string sig, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Error at %0t: %s expected %h, got %h", $time, sig, exp, act);
            test_errs++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Program builder and register model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] enc_addi(input logic [4:0] rd, rj, input logic [11:0] si12);
        return {6'h00, 4'ha, si12, rj, rd};
    endfunction

    function automatic logic [31:0] pc_of_next();
        return base_pc + 4 * prog.size();
    endfunction

    task automatic new_program();
        prog.delete();
        exp_pc.delete();
        exp_num.delete();
        exp_data.delete();
        exp_gap.delete();
        pending = 0;
        budget = 0;
        test_errs = 0;
    endtask

    // Cycle cost of the instruction or zero when it gets skipped
    task automatic emit(input logic [31:0] word, input int cost);
        prog.push_back(word);
        pending += cost;
        budget += cost;
    endtask

    task automatic expect_wb(input logic [4:0] rd, input logic [31:0] val);
        if (rd != 0) begin
            m_reg[rd] = val;
            exp_gap.push_back(exp_pc.size() == 0 ? -1 : pending);
            exp_pc.push_back(base_pc + 4 * (prog.size() - 1));
            exp_num.push_back(rd);
            exp_data.push_back(val);
            pending = 0;
        end
    endtask

    task automatic op_3r(input logic [4:0] op, rd, rj, rk);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        a = m_reg[rj];
        b = m_reg[rk];
        case (op)
            5'h02:   r = a - b;
            5'h04:   r = {31'b0, $signed(a) < $signed(b)};
            5'h05:   r = {31'b0, a < b};
            5'h08:   r = ~(a | b);
            5'h09:   r = a & b;
            5'h0a:   r = a | b;
            5'h0b:   r = a ^ b;
            default: r = a + b;
        endcase
        emit({6'h00, 4'h0, 2'h1, op, rk, rj, rd}, 4);
        expect_wb(rd, r);
    endtask

    task automatic op_shift(input logic [4:0] op, rd, rj, sa);
        logic [31:0] a;
        logic [31:0] r;
        a = m_reg[rj];
        if (op == 5'h01) r = a << sa;
        else if (op == 5'h09) r = a >> sa;
        else r = $signed(a) >>> sa;
        emit({6'h00, 4'h1, 2'h0, op, sa, rj, rd}, 4);
        expect_wb(rd, r);
    endtask

    task automatic op_addi(input logic [4:0] rd, rj, input logic [11:0] si12);
        emit(enc_addi(rd, rj, si12), 4);
        expect_wb(rd, m_reg[rj] + {{20{si12[11]}}, si12});
    endtask

    // lu12i.w then addi.w with the upper part rounded for the signed low part
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [19:0] hi;
        hi = value[31:12] + {19'b0, value[11]};
        emit({6'h05, 1'b0, hi, rd}, 4);
        expect_wb(rd, {hi, 12'h000});
        op_addi(rd, rd, value[11:0]);
    endtask

    // beq or bne over exactly one addi.w
    task automatic branch_over(input logic beq, input logic [4:0] rj, rd, fill_rd);
        logic taken;
        taken = (beq == (m_reg[rj] == m_reg[rd]));
        emit({(beq ? 6'h16 : 6'h17), 16'd2, rj, rd}, 2);
        if (taken) begin
            emit(enc_addi(fill_rd, 0, 12'h0ff), 0);
        end else begin
            op_addi(fill_rd, 0, 12'h0ff);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Running and checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_reset_outputs();
        compare_word("debug_wb_rf_we", '0, debug_wb_rf_we);
        compare_word("data_sram_we", '0, data_sram_we);
    endtask

    // Instruction port never writes
    task automatic check_tied_outputs();
        compare_word("inst_sram_we", '0, inst_sram_we);
        compare_word("inst_sram_wdata", '0, inst_sram_wdata);
    endtask

    task automatic run_program(input string name);
        int i;
        int n;
        int gap;
        emit({6'h14, 16'd0, 10'd0}, 0);  // b to itself
        @(negedge clk);
        reset = 1'b1;
        check_reset_outputs();
        @(negedge clk);
        got_pc.delete();
        got_num.delete();
        got_data.delete();
        got_cyc.delete();
        u_mem.clear_inst();
        for (i = 0; i < prog.size(); i++) begin
            u_mem.load_inst(i, prog[i]);
        end
        check_reset_outputs();
        @(negedge clk);
        check_reset_outputs();
        reset = 1'b0;
        n = 0;
        while (got_pc.size() < exp_pc.size() && n < budget + 20) begin
            @(negedge clk);
            n++;
        end
        repeat (10) @(negedge clk);  // Catch stray writes
        check_tied_outputs();
        assert (got_pc.size() == exp_pc.size()) else begin
            $display("Test %s logged %0d register writes instead of %0d",
                     name, got_pc.size(), exp_pc.size());
            test_errs++;
        end
        for (i = 0; i < exp_pc.size() && i < got_pc.size(); i++) begin
            compare_word("debug_wb_pc", exp_pc[i], got_pc[i]);
            compare_word("debug_wb_rf_wnum", exp_num[i], got_num[i]);
            compare_word("debug_wb_rf_wdata", exp_data[i], got_data[i]);
            if (exp_gap[i] >= 0) begin
                gap = got_cyc[i] - got_cyc[i-1];
                assert (gap == exp_gap[i]) else begin
                    $display("Write %0d of test %s came %0d cycles after the one before, not %0d",
                             i, name, gap, exp_gap[i]);
                    test_errs++;
                end
            end
        end
    endtask

    task automatic report_test(input string name);
        if (test_errs == 0) begin
            n_pass++;
            $display("Test %-13s ok", name);
        end else begin
            n_fail++;
            $display("Test %-13s failed with %0d errors", name, test_errs);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_reset();
        new_program();
        op_addi(1, 0, 12'h123);
        op_addi(0, 0, 12'h055);  // No trace expected
        op_3r(5'h00, 2, 0, 0);
        run_program("reset");
        report_test("reset");
    endtask

    task automatic test_alu();
        logic [4:0] ops [8];
        int k;
        ops = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09, 5'h0a, 5'h0b};
        new_program();
        load_const(4, $random(seed));
        load_const(5, $random(seed));
        for (k = 0; k < 8; k++) begin
            op_3r(ops[k], 5'd6 + k[4:0], 4, 5);
        end
        run_program("alu");
        report_test("alu");
    endtask

    task automatic test_shift_imm();
        logic [4:0] amts [4];
        int k;
        amts = '{5'd0, 5'd1, 5'd13, 5'd31};
        new_program();
        load_const(4, $random(seed) | 32'h8000_0000);  // Negative
        load_const(5, $random(seed) & 32'h7fff_ffff);
        for (k = 0; k < 4; k++) begin
            op_shift(5'h01, 6, 4, amts[k]);
            op_shift(5'h09, 7, 4, amts[k]);
            op_shift(5'h11, 8, 4, amts[k]);
            op_shift(5'h11, 9, 5, amts[k]);
        end
        op_addi(10, 4, 12'hffb);
        op_addi(11, 5, 12'h800);
        op_addi(12, 0, 12'hfff);
        run_program("shift/imm");
        report_test("shift/imm");
    endtask

    task automatic test_memory();
        logic [11:0] offs [2];
        logic [31:0] addr [2];
        logic [31:0] data [2];
        logic [4:0]  ld_rd;
        int k;
        offs = '{12'hff8, 12'h00c};
        new_program();
        load_const(4, 32'h0000_0400);  // Base address
        for (k = 0; k < 2; k++) begin
            load_const(5, $random(seed));
            addr[k] = m_reg[4] + {{20{offs[k][11]}}, offs[k]};
            data[k] = m_reg[5];
            ld_rd = 5'd6 + k[4:0];
            emit({6'h0a, 4'h6, offs[k], 5'd4, 5'd5}, 4);   // st.w
            emit({6'h0a, 4'h2, offs[k], 5'd4, ld_rd}, 5);  // ld.w
            expect_wb(ld_rd, data[k]);
        end
        run_program("memory");
        for (k = 0; k < 2; k++) begin
            compare_word($sformatf("dmem[%h]", addr[k]), data[k], u_mem.peek_data(addr[k]));
        end
        report_test("memory");
    endtask

    task automatic test_control_flow();
        logic [31:0] link_pc;
        new_program();
        op_addi(4, 0, 12'h007);
        op_addi(5, 0, 12'h007);
        op_addi(6, 0, 12'hffd);
        branch_over(1'b1, 4, 5, 10);
        op_addi(11, 0, 12'h001);
        branch_over(1'b0, 4, 5, 10);
        op_addi(11, 0, 12'h002);
        branch_over(1'b1, 4, 6, 10);
        op_addi(11, 0, 12'h003);
        branch_over(1'b0, 4, 6, 10);
        op_addi(11, 0, 12'h004);
        emit({6'h14, 16'd2, 10'd0}, 2);  // b over one
        emit(enc_addi(12, 0, 12'h001), 0);
        op_addi(12, 0, 12'h002);
        link_pc = pc_of_next();
        emit({6'h15, 16'd2, 10'd0}, 4);  // bl links into r1
        expect_wb(1, link_pc + 4);
        emit(enc_addi(13, 0, 12'h001), 0);
        // jirl r14, r1, 12 lands one past the next word
        link_pc = pc_of_next();
        emit({6'h13, 16'd3, 5'd1, 5'd14}, 4);
        expect_wb(14, link_pc + 4);
        emit(enc_addi(15, 0, 12'h001), 0);
        op_addi(15, 0, 12'h002);
        run_program("control flow");
        report_test("control flow");
    endtask

    initial begin
        reset = 1'b1;
        seed = 32'ha031_0be8;
        n_pass = 0;
        n_fail = 0;
        m_reg[0] = '0;
        u_mem.clear_inst();
        u_mem.fill_data();
        test_reset();
        test_alu();
        test_shift_imm();
        test_memory();
        test_control_flow();
        $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
design/mcpu_pkg.sv
design/mcpu_decode.sv
design/mcpu_alu.sv
design/mcpu_regfile.sv
design/mcpu_control.sv
design/mcpu_top.sv
sim/mcpu_mem_model.sv
sim/mcpu_tb.sv

// ==== Bender.yml ====
package:
  name: mcpu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/mcpu_pkg.sv
      - design/mcpu_decode.sv
      - design/mcpu_alu.sv
      - design/mcpu_regfile.sv
      - design/mcpu_control.sv
      - design/mcpu_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/mcpu_mem_model.sv
      - sim/mcpu_tb.sv
